//--- logic/demux_pkg.sv
`default_nettype none

package demux_pkg;

  // --------------------
  // sizes
  // --------------------
  // downstream ports
  localparam int unsigned NUM_PORTS  = 4;
  localparam int unsigned ID_WIDTH   = 4;
  // trackers only look at the low id bits
  localparam int unsigned LOOK_BITS  = 2;
  localparam int unsigned NUM_IDS    = 2 ** LOOK_BITS;
  // in-flight counter, full at all ones
  localparam int unsigned CNT_WIDTH  = 3;
  localparam int unsigned ADDR_WIDTH = 16;
  localparam int unsigned DATA_WIDTH = 32;
  localparam int unsigned LEN_WIDTH  = 4;
  localparam int unsigned SEL_WIDTH  = 2;

  typedef logic [SEL_WIDTH-1:0] port_sel_t;
  typedef logic [ID_WIDTH-1:0]  id_t;

  // --------------------
  // channel payloads
  // --------------------
  typedef struct packed {
    id_t                   id;
    logic [ADDR_WIDTH-1:0] addr;
    logic [LEN_WIDTH-1:0]  len;
  } aw_chan_t;

  typedef struct packed {
    id_t                   id;
    logic [ADDR_WIDTH-1:0] addr;
    logic [LEN_WIDTH-1:0]  len;
  } ar_chan_t;

  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic                  last;
  } w_chan_t;

  // upper resp bits carry the port tag in the bench
  typedef struct packed {
    id_t        id;
    logic [1:0] resp;
  } b_chan_t;

  typedef struct packed {
    id_t                   id;
    logic [DATA_WIDTH-1:0] data;
    logic [1:0]            resp;
    logic                  last;
  } r_chan_t;

  // --------------------
  // bundles
  // --------------------
  // upstream to downstream direction
  typedef struct packed {
    aw_chan_t aw;
    logic     aw_valid;
    w_chan_t  w;
    logic     w_valid;
    logic     b_ready;
    ar_chan_t ar;
    logic     ar_valid;
    logic     r_ready;
  } req_t;

  // downstream to upstream direction
  typedef struct packed {
    logic    aw_ready;
    logic    w_ready;
    logic    ar_ready;
    b_chan_t b;
    logic    b_valid;
    r_chan_t r;
    logic    r_valid;
  } resp_t;

  // idle: free to decide, held: offered and waiting for ready
  typedef enum logic {
    ROUTE_IDLE,
    ROUTE_HELD
  } route_state_e;

endpackage

`default_nettype wire

//--- logic/id_tracker.sv
`timescale 1ns/1ns
`default_nettype none

module id_tracker (
  input  logic                             clk_i,
  input  logic                             arst_n_i,
  // lookup
  input  logic [demux_pkg::LOOK_BITS-1:0]  lookup_id_i,
  output demux_pkg::port_sel_t             lookup_sel_o,
  output logic                             lookup_busy_o,
  output logic                             full_o,
  // push on a new transaction
  input  logic [demux_pkg::LOOK_BITS-1:0]  push_id_i,
  input  demux_pkg::port_sel_t             push_sel_i,
  input  logic                             push_i,
  // pop on the closing response
  input  logic [demux_pkg::LOOK_BITS-1:0]  pop_id_i,
  input  logic                             pop_i
);

  import demux_pkg::*;

  // one in-flight counter per low id value
  logic [NUM_IDS-1:0][CNT_WIDTH-1:0] cnt_q;
  // port that the id is bound to while its counter is nonzero
  port_sel_t [NUM_IDS-1:0]           sel_q;

  logic [NUM_IDS-1:0] push_hit;
  logic [NUM_IDS-1:0] pop_hit;
  logic [NUM_IDS-1:0] cnt_full;

  // --------------------
  // decode
  // --------------------
  always_comb begin
    for (int i = 0; i < NUM_IDS; i++) begin
      push_hit[i] = push_i && (push_id_i == LOOK_BITS'(i));
      pop_hit[i]  = pop_i && (pop_id_i == LOOK_BITS'(i));
      cnt_full[i] = &cnt_q[i];
    end
  end

  // --------------------
  // counters
  // --------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q <= '0;
    end else begin
      for (int i = 0; i < NUM_IDS; i++) begin
        // push and pop on the same id leave the count alone
        if (push_hit[i] && !pop_hit[i]) begin
          cnt_q[i] <= cnt_q[i] + 1'b1;
        end else if (pop_hit[i] && !push_hit[i]) begin
          cnt_q[i] <= cnt_q[i] - 1'b1;
        end
      end
    end
  end

  // destination only matters while busy
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      sel_q[push_id_i] <= push_sel_i;
    end
  end

  // --------------------
  // lookup
  // --------------------
  assign lookup_sel_o  = sel_q[lookup_id_i];
  assign lookup_busy_o = |cnt_q[lookup_id_i];
  // any full counter blocks new requests
  assign full_o        = |cnt_full;

endmodule

`default_nettype wire

//--- logic/resp_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module resp_arbiter #(
  parameter type payload_t = logic
) (
  input  logic                                clk_i,
  input  logic                                arst_n_i,
  input  payload_t [demux_pkg::NUM_PORTS-1:0] in_i,
  input  logic [demux_pkg::NUM_PORTS-1:0]     in_valid_i,
  output logic [demux_pkg::NUM_PORTS-1:0]     in_ready_o,
  output payload_t                            out_o,
  output logic                                out_valid_o,
  input  logic                                out_ready_i
);

  import demux_pkg::*;

  // round-robin start point
  port_sel_t ptr_q;
  // lock-in of an offered but stalled grant
  logic      lock_q;
  port_sel_t lock_idx_q;

  port_sel_t pick;
  port_sel_t cand;
  port_sel_t grant;
  logic      found;

  // --------------------
  // selection
  // --------------------
  // first valid input at or after the pointer
  always_comb begin
    pick  = ptr_q;
    found = 1'b0;
    for (int k = 0; k < NUM_PORTS; k++) begin
      cand = port_sel_t'((int'(ptr_q) + k) % NUM_PORTS);
      if (!found && in_valid_i[cand]) begin
        pick  = cand;
        found = 1'b1;
      end
    end
  end

  // a stalled grant stays put so the output never changes under valid
  assign grant       = lock_q ? lock_idx_q : pick;
  assign out_o       = in_i[grant];
  assign out_valid_o = in_valid_i[grant];

  always_comb begin
    in_ready_o        = '0;
    in_ready_o[grant] = out_ready_i;
  end

  // --------------------
  // state
  // --------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ptr_q      <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else if (out_valid_o && out_ready_i) begin
      // move past the winner
      ptr_q  <= port_sel_t'((int'(grant) + 1) % NUM_PORTS);
      lock_q <= 1'b0;
    end else if (out_valid_o) begin
      lock_q     <= 1'b1;
      lock_idx_q <= grant;
    end
  end

endmodule

`default_nettype wire

//--- logic/write_router.sv
`timescale 1ns/1ns
`default_nettype none

module write_router (
  input  logic                                         clk_i,
  input  logic                                         arst_n_i,
  // upstream
  input  demux_pkg::aw_chan_t                          aw_i,
  input  demux_pkg::port_sel_t                         aw_sel_i,
  input  logic                                         aw_valid_i,
  output logic                                         aw_ready_o,
  input  demux_pkg::w_chan_t                           w_i,
  input  logic                                         w_valid_i,
  output logic                                         w_ready_o,
  output demux_pkg::b_chan_t                           b_o,
  output logic                                         b_valid_o,
  input  logic                                         b_ready_i,
  // downstream handshakes
  output logic [demux_pkg::NUM_PORTS-1:0]              mst_aw_valid_o,
  input  logic [demux_pkg::NUM_PORTS-1:0]              mst_aw_ready_i,
  output logic [demux_pkg::NUM_PORTS-1:0]              mst_w_valid_o,
  input  logic [demux_pkg::NUM_PORTS-1:0]              mst_w_ready_i,
  input  demux_pkg::b_chan_t [demux_pkg::NUM_PORTS-1:0] mst_b_i,
  input  logic [demux_pkg::NUM_PORTS-1:0]              mst_b_valid_i,
  output logic [demux_pkg::NUM_PORTS-1:0]              mst_b_ready_o
);

  import demux_pkg::*;

  route_state_e state_q, state_d;

  // id tracker
  port_sel_t trk_sel;
  logic      trk_busy;
  logic      trk_full;

  // open W bursts, all bound for w_sel_q
  logic [CNT_WIDTH-1:0] w_open_q;
  port_sel_t            w_sel_q;
  port_sel_t            w_sel;
  logic                 w_sel_valid;
  logic                 w_cnt_up;
  logic                 w_cnt_down;

  logic gate_open;
  logic aw_valid_int;

  // --------------------
  // AW control
  // --------------------
  // same id stays on one port, W data must not cross ports
  assign gate_open = aw_valid_i && !trk_full && (w_open_q != '1) &&
                     ((w_open_q == '0) || (w_sel_q == aw_sel_i)) &&
                     (!trk_busy || (trk_sel == aw_sel_i));

  always_comb begin
    state_d      = state_q;
    aw_valid_int = 1'b0;
    w_cnt_up     = 1'b0;
    case (state_q)
      ROUTE_HELD: begin
        // decision already pushed, just wait
        aw_valid_int = 1'b1;
        if (mst_aw_ready_i[aw_sel_i]) begin
          state_d = ROUTE_IDLE;
        end
      end
      default: begin
        if (gate_open) begin
          aw_valid_int = 1'b1;
          // W may follow before the AW is taken
          w_cnt_up     = 1'b1;
          if (!mst_aw_ready_i[aw_sel_i]) begin
            state_d = ROUTE_HELD;
          end
        end
      end
    endcase
  end

  assign aw_ready_o = aw_valid_int && mst_aw_ready_i[aw_sel_i];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= ROUTE_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // --------------------
  // W steering
  // --------------------
  assign w_sel       = (w_open_q != '0) ? w_sel_q : aw_sel_i;
  assign w_sel_valid = w_cnt_up || (w_open_q != '0);
  assign w_ready_o   = w_sel_valid && mst_w_ready_i[w_sel];
  // a last beat closes the oldest burst
  assign w_cnt_down  = w_valid_i && w_ready_o && w_i.last;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      w_open_q <= '0;
    end else if (w_cnt_up && !w_cnt_down) begin
      w_open_q <= w_open_q + 1'b1;
    end else if (w_cnt_down && !w_cnt_up) begin
      w_open_q <= w_open_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (w_cnt_up) begin
      w_sel_q <= aw_sel_i;
    end
  end

  // one-hot valids toward the ports
  always_comb begin
    for (int p = 0; p < NUM_PORTS; p++) begin
      mst_aw_valid_o[p] = aw_valid_int && (aw_sel_i == port_sel_t'(p));
      mst_w_valid_o[p]  = w_valid_i && w_sel_valid && (w_sel == port_sel_t'(p));
    end
  end

  // --------------------
  // tracking and B merge
  // --------------------
  id_tracker u_aw_tracker (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .lookup_id_i   (aw_i.id[LOOK_BITS-1:0]),
    .lookup_sel_o  (trk_sel),
    .lookup_busy_o (trk_busy),
    .full_o        (trk_full),
    .push_id_i     (aw_i.id[LOOK_BITS-1:0]),
    .push_sel_i    (aw_sel_i),
    .push_i        (aw_ready_o),
    .pop_id_i      (b_o.id[LOOK_BITS-1:0]),
    .pop_i         (b_valid_o && b_ready_i)
  );

  resp_arbiter #(
    .payload_t (b_chan_t)
  ) u_b_arb (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .in_i        (mst_b_i),
    .in_valid_i  (mst_b_valid_i),
    .in_ready_o  (mst_b_ready_o),
    .out_o       (b_o),
    .out_valid_o (b_valid_o),
    .out_ready_i (b_ready_i)
  );

endmodule

`default_nettype wire

//--- logic/read_router.sv
`timescale 1ns/1ns
`default_nettype none

module read_router (
  input  logic                                          clk_i,
  input  logic                                          arst_n_i,
  // upstream
  input  demux_pkg::ar_chan_t                           ar_i,
  input  demux_pkg::port_sel_t                          ar_sel_i,
  input  logic                                          ar_valid_i,
  output logic                                          ar_ready_o,
  output demux_pkg::r_chan_t                            r_o,
  output logic                                          r_valid_o,
  input  logic                                          r_ready_i,
  // downstream handshakes
  output logic [demux_pkg::NUM_PORTS-1:0]               mst_ar_valid_o,
  input  logic [demux_pkg::NUM_PORTS-1:0]               mst_ar_ready_i,
  input  demux_pkg::r_chan_t [demux_pkg::NUM_PORTS-1:0] mst_r_i,
  input  logic [demux_pkg::NUM_PORTS-1:0]               mst_r_valid_i,
  output logic [demux_pkg::NUM_PORTS-1:0]               mst_r_ready_o
);

  import demux_pkg::*;

  route_state_e state_q, state_d;

  port_sel_t trk_sel;
  logic      trk_busy;
  logic      trk_full;
  logic      ar_valid_int;

  // --------------------
  // AR control
  // --------------------
  always_comb begin
    state_d      = state_q;
    ar_valid_int = 1'b0;
    case (state_q)
      ROUTE_HELD: begin
        ar_valid_int = 1'b1;
        if (mst_ar_ready_i[ar_sel_i]) begin
          state_d = ROUTE_IDLE;
        end
      end
      default: begin
        // id idle or already on this port
        if (ar_valid_i && !trk_full && (!trk_busy || (trk_sel == ar_sel_i))) begin
          ar_valid_int = 1'b1;
          if (!mst_ar_ready_i[ar_sel_i]) begin
            state_d = ROUTE_HELD;
          end
        end
      end
    endcase
  end

  assign ar_ready_o = ar_valid_int && mst_ar_ready_i[ar_sel_i];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= ROUTE_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    for (int p = 0; p < NUM_PORTS; p++) begin
      mst_ar_valid_o[p] = ar_valid_int && (ar_sel_i == port_sel_t'(p));
    end
  end

  // --------------------
  // tracking and R merge
  // --------------------
  // counter drops only on the last beat of a burst
  id_tracker u_ar_tracker (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .lookup_id_i   (ar_i.id[LOOK_BITS-1:0]),
    .lookup_sel_o  (trk_sel),
    .lookup_busy_o (trk_busy),
    .full_o        (trk_full),
    .push_id_i     (ar_i.id[LOOK_BITS-1:0]),
    .push_sel_i    (ar_sel_i),
    .push_i        (ar_ready_o),
    .pop_id_i      (r_o.id[LOOK_BITS-1:0]),
    .pop_i         (r_valid_o && r_ready_i && r_o.last)
  );

  resp_arbiter #(
    .payload_t (r_chan_t)
  ) u_r_arb (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .in_i        (mst_r_i),
    .in_valid_i  (mst_r_valid_i),
    .in_ready_o  (mst_r_ready_o),
    .out_o       (r_o),
    .out_valid_o (r_valid_o),
    .out_ready_i (r_ready_i)
  );

endmodule

`default_nettype wire

//--- logic/axi_demux_top.sv
`timescale 1ns/1ns
`default_nettype none

module axi_demux_top (
  input  logic                                        clk_i,
  input  logic                                        arst_n_i,
  // upstream port with its routing selects
  input  demux_pkg::req_t                             slv_req_i,
  input  demux_pkg::port_sel_t                        slv_aw_sel_i,
  input  demux_pkg::port_sel_t                        slv_ar_sel_i,
  output demux_pkg::resp_t                            slv_resp_o,
  // downstream ports
  output demux_pkg::req_t  [demux_pkg::NUM_PORTS-1:0] mst_req_o,
  input  demux_pkg::resp_t [demux_pkg::NUM_PORTS-1:0] mst_resp_i
);

  import demux_pkg::*;

  // per-port handshakes, unpacked from and packed into the structs
  logic    [NUM_PORTS-1:0] aw_valid, aw_ready;
  logic    [NUM_PORTS-1:0] w_valid, w_ready;
  logic    [NUM_PORTS-1:0] b_valid, b_ready;
  logic    [NUM_PORTS-1:0] ar_valid, ar_ready;
  logic    [NUM_PORTS-1:0] r_valid, r_ready;
  b_chan_t [NUM_PORTS-1:0] b_chans;
  r_chan_t [NUM_PORTS-1:0] r_chans;

  // --------------------
  // port structs
  // --------------------
  always_comb begin
    for (int p = 0; p < NUM_PORTS; p++) begin
      aw_ready[p] = mst_resp_i[p].aw_ready;
      w_ready[p]  = mst_resp_i[p].w_ready;
      ar_ready[p] = mst_resp_i[p].ar_ready;
      b_valid[p]  = mst_resp_i[p].b_valid;
      b_chans[p]  = mst_resp_i[p].b;
      r_valid[p]  = mst_resp_i[p].r_valid;
      r_chans[p]  = mst_resp_i[p].r;
      // payloads go everywhere, only the valids select
      mst_req_o[p].aw       = slv_req_i.aw;
      mst_req_o[p].aw_valid = aw_valid[p];
      mst_req_o[p].w        = slv_req_i.w;
      mst_req_o[p].w_valid  = w_valid[p];
      mst_req_o[p].b_ready  = b_ready[p];
      mst_req_o[p].ar       = slv_req_i.ar;
      mst_req_o[p].ar_valid = ar_valid[p];
      mst_req_o[p].r_ready  = r_ready[p];
    end
  end

  // --------------------
  // routers
  // --------------------
  write_router u_write_router (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .aw_i           (slv_req_i.aw),
    .aw_sel_i       (slv_aw_sel_i),
    .aw_valid_i     (slv_req_i.aw_valid),
    .aw_ready_o     (slv_resp_o.aw_ready),
    .w_i            (slv_req_i.w),
    .w_valid_i      (slv_req_i.w_valid),
    .w_ready_o      (slv_resp_o.w_ready),
    .b_o            (slv_resp_o.b),
    .b_valid_o      (slv_resp_o.b_valid),
    .b_ready_i      (slv_req_i.b_ready),
    .mst_aw_valid_o (aw_valid),
    .mst_aw_ready_i (aw_ready),
    .mst_w_valid_o  (w_valid),
    .mst_w_ready_i  (w_ready),
    .mst_b_i        (b_chans),
    .mst_b_valid_i  (b_valid),
    .mst_b_ready_o  (b_ready)
  );

  read_router u_read_router (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .ar_i           (slv_req_i.ar),
    .ar_sel_i       (slv_ar_sel_i),
    .ar_valid_i     (slv_req_i.ar_valid),
    .ar_ready_o     (slv_resp_o.ar_ready),
    .r_o            (slv_resp_o.r),
    .r_valid_o      (slv_resp_o.r_valid),
    .r_ready_i      (slv_req_i.r_ready),
    .mst_ar_valid_o (ar_valid),
    .mst_ar_ready_i (ar_ready),
    .mst_r_i        (r_chans),
    .mst_r_valid_i  (r_valid),
    .mst_r_ready_o  (r_ready)
  );

endmodule

`default_nettype wire

//--- bench/port_slave.sv
`timescale 1ns/1ns
`default_nettype none

module port_slave #(
  parameter int unsigned PORT_IDX = 0
) (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  demux_pkg::req_t   req_i,
  output demux_pkg::resp_t  resp_o
);

  import demux_pkg::*;

  integer      seed;
  // accepted addresses, oldest first
  aw_chan_t    aw_q[$];
  ar_chan_t    ar_q[$];
  b_chan_t     b_q[$];
  b_chan_t     b_next;
  ar_chan_t    ar_head;
  int unsigned w_done;
  int unsigned r_beat;
  logic        b_hs;
  logic        r_hs;

  initial begin
    seed   = 32'hedde + PORT_IDX;
    resp_o = '0;
    w_done = 0;
    r_beat = 0;
    forever begin
      // --------------------
      // sample transfers that complete at the next edge
      // --------------------
      @(negedge clk_i);
      if (req_i.aw_valid && resp_o.aw_ready) begin
        aw_q.push_back(req_i.aw);
      end
      if (req_i.ar_valid && resp_o.ar_ready) begin
        ar_q.push_back(req_i.ar);
      end
      // W can run ahead of its AW, so count finished bursts apart
      if (req_i.w_valid && resp_o.w_ready && req_i.w.last) begin
        w_done++;
      end
      b_hs = resp_o.b_valid && req_i.b_ready;
      r_hs = resp_o.r_valid && req_i.r_ready;
      while (w_done > 0 && aw_q.size() > 0) begin
        b_next.id   = aw_q.pop_front().id;
        // port tag in the resp bits
        b_next.resp = 2'(PORT_IDX);
        b_q.push_back(b_next);
        w_done--;
      end

      // --------------------
      // drive just after the edge
      // --------------------
      @(posedge clk_i);
      #1;
      resp_o.aw_ready = arst_n_i && (($random(seed) & 3) != 0);
      resp_o.w_ready  = arst_n_i && (($random(seed) & 3) != 0);
      resp_o.ar_ready = arst_n_i && (($random(seed) & 3) != 0);
      if (b_hs) begin
        resp_o.b_valid = 1'b0;
      end
      if (!resp_o.b_valid && b_q.size() > 0 && ($random(seed) & 1)) begin
        resp_o.b       = b_q.pop_front();
        resp_o.b_valid = 1'b1;
      end
      if (r_hs) begin
        resp_o.r_valid = 1'b0;
        if (resp_o.r.last) begin
          void'(ar_q.pop_front());
          r_beat = 0;
        end else begin
          r_beat++;
        end
      end
      if (!resp_o.r_valid && ar_q.size() > 0 && ($random(seed) & 1)) begin
        ar_head        = ar_q[0];
        resp_o.r.id    = ar_head.id;
        resp_o.r.data  = DATA_WIDTH'(ar_head.addr) + DATA_WIDTH'(r_beat);
        resp_o.r.resp  = 2'(PORT_IDX);
        resp_o.r.last  = (r_beat == ar_head.len);
        resp_o.r_valid = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- bench/tb_demux.sv
`timescale 1ns/1ns
`default_nettype none

module tb_demux;

  import demux_pkg::*;

  localparam int unsigned NUM_TXN      = 300;
  localparam int unsigned MAX_LEN      = 4;
  localparam int unsigned NUM_FULL_IDS = 2 ** ID_WIDTH;
  localparam int unsigned MAX_OPEN     = 2 ** CNT_WIDTH - 1;
  // closing stretch of each stream that piles up one low id on one port
  localparam int unsigned HOT_TXN      = 60;
  // 40 cycles of 10 ns for each of the reads and writes
  localparam longint unsigned TIMEOUT_NS = 2 * NUM_TXN * 40 * 10;

  typedef struct packed {
    port_sel_t             sel;
    id_t                   id;
    logic [ADDR_WIDTH-1:0] addr;
    logic [LEN_WIDTH-1:0]  len;
  } req_exp_t;

  typedef struct packed {
    port_sel_t sel;
    w_chan_t   w;
  } w_exp_t;

  logic                  clk;
  logic                  arst_n;
  req_t                  slv_req;
  resp_t                 slv_resp;
  port_sel_t             aw_sel;
  port_sel_t             ar_sel;
  req_t [NUM_PORTS-1:0]  mst_req;
  wire resp_t [NUM_PORTS-1:0] mst_resp;

  // upstream drive
  aw_chan_t aw;
  logic     aw_valid;
  w_chan_t  w;
  logic     w_valid;
  ar_chan_t ar;
  logic     ar_valid;
  logic     b_ready;
  logic     r_ready;

  integer seed;

  // --------------------
  // reference model state
  // --------------------
  req_exp_t    exp_aw[$];
  req_exp_t    exp_ar[$];
  w_exp_t      exp_w[$];
  req_exp_t    burst_q[$];
  port_sel_t   exp_b[NUM_FULL_IDS][$];
  req_exp_t    exp_r[NUM_FULL_IDS][$];
  int unsigned r_beat[NUM_FULL_IDS];
  // outstanding per low id and its port
  int unsigned wr_cnt[NUM_IDS];
  port_sel_t   wr_port[NUM_IDS];
  int unsigned rd_cnt[NUM_IDS];
  port_sel_t   rd_port[NUM_IDS];

  req_exp_t              mon_e;
  w_exp_t                mon_w;
  id_t                   mon_id;
  logic [LOOK_BITS-1:0]  mon_lo;
  logic [DATA_WIDTH-1:0] mon_data;
  logic [NUM_PORTS-1:0]  aw_vec;
  logic [NUM_PORTS-1:0]  ar_vec;

  always_comb begin
    slv_req          = '0;
    slv_req.aw       = aw;
    slv_req.aw_valid = aw_valid;
    slv_req.w        = w;
    slv_req.w_valid  = w_valid;
    slv_req.b_ready  = b_ready;
    slv_req.ar       = ar;
    slv_req.ar_valid = ar_valid;
    slv_req.r_ready  = r_ready;
  end

  axi_demux_top UUT (
    .clk_i        (clk),
    .arst_n_i     (arst_n),
    .slv_req_i    (slv_req),
    .slv_aw_sel_i (aw_sel),
    .slv_ar_sel_i (ar_sel),
    .slv_resp_o   (slv_resp),
    .mst_req_o    (mst_req),
    .mst_resp_i   (mst_resp)
  );

  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
    port_slave #(
      .PORT_IDX (p)
    ) u_port (
      .clk_i    (clk),
      .arst_n_i (arst_n),
      .req_i    (mst_req[p]),
      .resp_o   (mst_resp[p])
    );
  end

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] next_random();
    return $random(seed);
  endfunction

  task automatic check_value(input string name, input logic [63:0] exp_val,
                             input logic [63:0] act_val);
    if (exp_val !== act_val) begin
      $display("[ERROR] %0t ns %s expected %0h actual %0h", $time, name, exp_val, act_val);
      $display("** FAIL **");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  // nothing may move while idle
  task automatic check_quiet();
    check_value("upstream ready and valid outputs", 0,
                {slv_resp.aw_ready, slv_resp.w_ready, slv_resp.ar_ready,
                 slv_resp.b_valid, slv_resp.r_valid});
    for (int p = 0; p < NUM_PORTS; p++) begin
      check_value("downstream valids", 0,
                  {mst_req[p].aw_valid, mst_req[p].w_valid, mst_req[p].ar_valid});
    end
  endtask

  function automatic req_exp_t random_request(input logic hot);
    req_exp_t e;
    e.sel  = port_sel_t'(next_random());
    e.id   = id_t'(next_random());
    e.addr = ADDR_WIDTH'(next_random());
    e.len  = LEN_WIDTH'(next_random() % MAX_LEN);
    // hot requests share low id 0 on port 0 so the counters fill up
    if (hot) begin
      e.id[LOOK_BITS-1:0] = '0;
      e.sel               = '0;
    end
    return e;
  endfunction

  // --------------------
  // upstream drivers
  // --------------------
  task automatic drive_writes();
    req_exp_t e;
    logic     hs;
    for (int i = 0; i < NUM_TXN; i++) begin
      repeat (next_random() & 3) begin
        @(posedge clk);
        #1;
      end
      e = random_request(i >= int'(NUM_TXN - HOT_TXN));
      exp_aw.push_back(e);
      exp_b[e.id].push_back(e.sel);
      burst_q.push_back(e);
      aw       = '{id: e.id, addr: e.addr, len: e.len};
      aw_sel   = e.sel;
      aw_valid = 1'b1;
      do begin
        @(negedge clk);
        hs = slv_resp.aw_ready;
        @(posedge clk);
        #1;
      end while (!hs);
      aw_valid = 1'b0;
    end
  endtask

  // beats follow the AW order
  task automatic drive_wdata();
    req_exp_t e;
    w_exp_t   x;
    logic     hs;
    for (int i = 0; i < NUM_TXN; i++) begin
      while (burst_q.size() == 0) begin
        @(posedge clk);
        #1;
      end
      e = burst_q.pop_front();
      for (int b = 0; b <= int'(e.len); b++) begin
        x.sel    = e.sel;
        x.w.data = next_random();
        x.w.last = (b == int'(e.len));
        exp_w.push_back(x);
        w       = x.w;
        w_valid = 1'b1;
        do begin
          @(negedge clk);
          hs = slv_resp.w_ready;
          @(posedge clk);
          #1;
        end while (!hs);
        w_valid = 1'b0;
        if (next_random() & 1) begin
          @(posedge clk);
          #1;
        end
      end
    end
  endtask

  task automatic drive_reads();
    req_exp_t e;
    logic     hs;
    for (int i = 0; i < NUM_TXN; i++) begin
      repeat (next_random() & 3) begin
        @(posedge clk);
        #1;
      end
      e = random_request(i >= int'(NUM_TXN - HOT_TXN));
      exp_ar.push_back(e);
      exp_r[e.id].push_back(e);
      ar       = '{id: e.id, addr: e.addr, len: e.len};
      ar_sel   = e.sel;
      ar_valid = 1'b1;
      do begin
        @(negedge clk);
        hs = slv_resp.ar_ready;
        @(posedge clk);
        #1;
      end while (!hs);
      ar_valid = 1'b0;
    end
  endtask

  // random back-pressure on B and R
  initial begin
    forever begin
      @(posedge clk);
      #1;
      b_ready = (next_random() & 3) != 0;
      r_ready = (next_random() & 3) != 0;
    end
  end

  // --------------------
  // monitor, sampled mid-cycle
  // --------------------
  always @(negedge clk) begin
    if (arst_n) begin
      for (int p = 0; p < NUM_PORTS; p++) begin
        aw_vec[p] = mst_req[p].aw_valid;
        ar_vec[p] = mst_req[p].ar_valid;
        if (mst_req[p].aw_valid && mst_resp[p].aw_ready) begin
          check_value("AW expected", 1, exp_aw.size() > 0);
          mon_e = exp_aw.pop_front();
          check_value("aw port", mon_e.sel, p);
          check_value("aw.id", mon_e.id, mst_req[p].aw.id);
          check_value("aw.addr", mon_e.addr, mst_req[p].aw.addr);
          check_value("aw.len", mon_e.len, mst_req[p].aw.len);
          mon_lo = mon_e.id[LOOK_BITS-1:0];
          if (wr_cnt[mon_lo] != 0) begin
            check_value("aw port of busy id", wr_port[mon_lo], p);
          end
          wr_cnt[mon_lo]++;
          wr_port[mon_lo] = port_sel_t'(p);
          check_value("writes open per id in range", 1, wr_cnt[mon_lo] <= MAX_OPEN);
        end
        if (mst_req[p].w_valid && mst_resp[p].w_ready) begin
          check_value("W beat expected", 1, exp_w.size() > 0);
          mon_w = exp_w.pop_front();
          check_value("w port", mon_w.sel, p);
          check_value("w.data", mon_w.w.data, mst_req[p].w.data);
          check_value("w.last", mon_w.w.last, mst_req[p].w.last);
        end
        if (mst_req[p].ar_valid && mst_resp[p].ar_ready) begin
          check_value("AR expected", 1, exp_ar.size() > 0);
          mon_e = exp_ar.pop_front();
          check_value("ar port", mon_e.sel, p);
          check_value("ar.id", mon_e.id, mst_req[p].ar.id);
          check_value("ar.addr", mon_e.addr, mst_req[p].ar.addr);
          check_value("ar.len", mon_e.len, mst_req[p].ar.len);
          mon_lo = mon_e.id[LOOK_BITS-1:0];
          if (rd_cnt[mon_lo] != 0) begin
            check_value("ar port of busy id", rd_port[mon_lo], p);
          end
          rd_cnt[mon_lo]++;
          rd_port[mon_lo] = port_sel_t'(p);
          check_value("reads open per id in range", 1, rd_cnt[mon_lo] <= MAX_OPEN);
        end
        // a response taken from a port goes upstream in the same cycle
        if (mst_resp[p].b_valid && mst_req[p].b_ready) begin
          check_value("b taken from port", {1'b1, mst_resp[p].b},
                      {slv_resp.b_valid && slv_req.b_ready, slv_resp.b});
        end
        if (mst_resp[p].r_valid && mst_req[p].r_ready) begin
          check_value("r taken from port", {1'b1, mst_resp[p].r},
                      {slv_resp.r_valid && slv_req.r_ready, slv_resp.r});
        end
      end
      check_value("aw valids one-hot", 1, $countones(aw_vec) <= 1);
      check_value("ar valids one-hot", 1, $countones(ar_vec) <= 1);

      if (slv_resp.b_valid && slv_req.b_ready) begin
        mon_id = slv_resp.b.id;
        check_value("B for an issued id", 1, exp_b[mon_id].size() > 0);
        check_value("b.resp port tag", exp_b[mon_id].pop_front(), slv_resp.b.resp);
        wr_cnt[mon_id[LOOK_BITS-1:0]]--;
      end
      if (slv_resp.r_valid && slv_req.r_ready) begin
        mon_id = slv_resp.r.id;
        check_value("R for an issued id", 1, exp_r[mon_id].size() > 0);
        mon_e    = exp_r[mon_id][0];
        mon_data = DATA_WIDTH'(mon_e.addr) + DATA_WIDTH'(r_beat[mon_id]);
        check_value("r.data", mon_data, slv_resp.r.data);
        check_value("r.resp port tag", mon_e.sel, slv_resp.r.resp);
        check_value("r.last", r_beat[mon_id] == mon_e.len, slv_resp.r.last);
        if (slv_resp.r.last) begin
          void'(exp_r[mon_id].pop_front());
          r_beat[mon_id] = 0;
          rd_cnt[mon_id[LOOK_BITS-1:0]]--;
        end else begin
          r_beat[mon_id]++;
        end
      end
    end
  end

  function automatic logic drained();
    logic empty;
    empty = exp_aw.size() == 0 && exp_w.size() == 0 && exp_ar.size() == 0;
    for (int i = 0; i < NUM_FULL_IDS; i++) begin
      if (exp_b[i].size() != 0 || exp_r[i].size() != 0) begin
        empty = 1'b0;
      end
    end
    return empty;
  endfunction

  initial begin
    #(TIMEOUT_NS);
    $display("timeout: the transactions did not drain, the DUT appears to hang");
    $display("** FAIL **");
    $fatal(1, "watchdog expired");
  end

  // --------------------
  // main sequence
  // --------------------
  initial begin
    seed     = 32'hedde;
    arst_n   = 1'b0;
    aw       = '0;
    aw_sel   = '0;
    aw_valid = 1'b0;
    w        = '0;
    w_valid  = 1'b0;
    ar       = '0;
    ar_sel   = '0;
    ar_valid = 1'b0;
    b_ready  = 1'b0;
    r_ready  = 1'b0;
    for (int i = 0; i < NUM_FULL_IDS; i++) begin
      r_beat[i] = 0;
    end
    for (int i = 0; i < NUM_IDS; i++) begin
      wr_cnt[i] = 0;
      rd_cnt[i] = 0;
    end
    for (int c = 0; c < 16; c++) begin
      @(negedge clk);
      check_quiet();
    end
    @(posedge clk);
    #1;
    arst_n = 1'b1;
    repeat (4) begin
      @(negedge clk);
      check_quiet();
    end
    @(posedge clk);
    #1;
    fork
      drive_writes();
      drive_wdata();
      drive_reads();
    join
    while (!drained()) begin
      @(posedge clk);
      #1;
    end
    repeat (4) @(posedge clk);
    for (int i = 0; i < NUM_IDS; i++) begin
      check_value("writes left open", 0, wr_cnt[i]);
      check_value("reads left open", 0, rd_cnt[i]);
    end
    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
logic/demux_pkg.sv
logic/id_tracker.sv
logic/resp_arbiter.sv
logic/write_router.sv
logic/read_router.sv
logic/axi_demux_top.sv
bench/port_slave.sv
bench/tb_demux.sv

//--- run.sh
#!/bin/sh
# build and run the demux testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f sim.f --top-module tb_demux \
  -Mdir obj_dir -o tb_demux > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "build failed"
  exit 1
fi

./obj_dir/tb_demux > sim.log 2>&1
status=$?
cat sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi
exit 0
